//--- romdl_map_pkg.sv
/*
  Address map of the downloaded game image.
  Byte addresses are counted after the header is stripped.
  Bank and PROM depths are sized for simulation, not for a full game.
*/

package romdl_map_pkg;

    // leading image bytes kept by the header latch and never sent to memory
    localparam int HEADER_LEN = 16;

    // first post-header byte of banks 1 to 3, bank 0 starts at zero
    localparam logic [24:0] BA1_START = 25'h100;
    localparam logic [24:0] BA2_START = 25'h200;
    localparam logic [24:0] BA3_START = 25'h300;

    // everything from here upward goes to the PROM
    localparam logic [24:0] PROM_START = 25'h380;

    // set to swap the byte lanes of each 16-bit SDRAM word
    localparam logic SWAB = 1'b0;

    // per-bank SDRAM store, in 16-bit words
    localparam int BANK_WORDS = 128;
    localparam int BANK_AW    = 7;

    // PROM store, in bytes
    localparam int PROM_BYTES = 128;
    localparam int PROM_AW    = 7;

endpackage

//--- romdl_bus_pkg.sv
/*
  Bus types shared by the download path.
  The SDRAM mask is active low, one bit per byte lane, bit 1 is the upper byte.
*/

package romdl_bus_pkg;

    // one byte from the host, valid while ioctl_wr is high
    typedef struct packed {
        logic [24:0] addr;
        logic [7:0]  data;
    } host_beat_t;

    // one SDRAM programming write
    // the byte is copied to both lanes and the mask picks the lane to write
    typedef struct packed {
        logic [21:0] addr;
        logic [1:0]  ba;
        logic [15:0] data;
        logic [1:0]  mask;
    } sdram_prog_t;

    // one PROM write, single cycle
    typedef struct packed {
        logic [21:0] addr;
        logic [7:0]  data;
    } prom_wr_t;

    // header bytes, entry 0 is the first byte of the image
    typedef logic [romdl_map_pkg::HEADER_LEN-1:0][7:0] header_bytes_t;

endpackage

//--- mem_sync.sv
/*
  Single write port, registered read port.
  16-bit words honour the active-low lane mask, other widths ignore it.
  Contents are not reset.
*/

`timescale 1ns/1ps

module mem_sync #(
    parameter type word_t = logic [15:0],
    parameter int  DEPTH  = romdl_map_pkg::BANK_WORDS,
    parameter int  AW     = romdl_map_pkg::BANK_AW
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  word_t         wdata,
    input  logic [1:0]    wmask_n,
    input  logic [AW-1:0] raddr,
    output word_t         rdata
);

    word_t mem [DEPTH];

    if ($bits(word_t) == 16) begin : g_lane_wr
        // each lane is written only when its mask bit is low
        always_ff @(posedge clk) begin
            if (we && !wmask_n[1]) mem[waddr][15:8] <= wdata[15:8];
            if (we && !wmask_n[0]) mem[waddr][7:0]  <= wdata[7:0];
        end
    end else begin : g_word_wr
        always_ff @(posedge clk) begin
            if (we) mem[waddr] <= wdata;
        end
    end

    // read data appears one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- rom_dwnld.sv
/*
  Splits the host byte stream into header, SDRAM bank and PROM writes.
  The host has no back-pressure, so a new strobe must not arrive while
  prog_we is still waiting for sdram_ack.
*/

`timescale 1ns/1ps

module rom_dwnld (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       downloading,
    input  romdl_bus_pkg::host_beat_t  beat,
    input  logic                       ioctl_wr,
    input  logic                       sdram_ack,
    output romdl_bus_pkg::sdram_prog_t prog,
    output logic                       prog_we,
    output romdl_bus_pkg::prom_wr_t    prom,
    output logic                       prom_we,
    output logic                       header
);

    logic [24:0] part;
    logic [24:0] bank_start;
    logic [24:0] offset;
    logic [1:0]  bank;
    logic        is_prom;
    logic        accept;

    ////////////////////////////////////////////////////////////
    // address decode

    // header bytes are only recognised while a download is running
    always_comb begin
        header = downloading && (beat.addr < 25'(romdl_map_pkg::HEADER_LEN));
        part   = beat.addr - 25'(romdl_map_pkg::HEADER_LEN);
    end

    assign is_prom = part >= romdl_map_pkg::PROM_START;

    // the highest bank whose start is at or below the byte wins
    always_comb begin
        if (part >= romdl_map_pkg::BA3_START) begin
            bank       = 2'd3;
            bank_start = romdl_map_pkg::BA3_START;
        end else if (part >= romdl_map_pkg::BA2_START) begin
            bank       = 2'd2;
            bank_start = romdl_map_pkg::BA2_START;
        end else if (part >= romdl_map_pkg::BA1_START) begin
            bank       = 2'd1;
            bank_start = romdl_map_pkg::BA1_START;
        end else begin
            bank       = 2'd0;
            bank_start = 25'd0;
        end
        offset = part - bank_start;
    end

    // header strobes are taken by the header latch and go nowhere else
    assign accept = ioctl_wr && downloading && !header;

    ////////////////////////////////////////////////////////////
    // write payload

    // payload only moves on an accepted strobe, so it is stable under prog_we
    always_ff @(posedge clk) begin
        if (accept) begin
            prog.addr <= offset[22:1];
            prog.ba   <= bank;
            prog.data <= {2{beat.data}};
            // even offsets land in the upper lane unless the lanes are swapped
            prog.mask <= (offset[0] ^ romdl_map_pkg::SWAB) ? 2'b10 : 2'b01;
            prom.addr <= part[21:0];
            prom.data <= beat.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // write enables

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            // PROM writes last one cycle
            prom_we <= accept && is_prom;
            if (accept) begin
                prog_we <= !is_prom;
            end else if (!downloading || sdram_ack) begin
                // the SDRAM write is held until acknowledged or the download ends
                prog_we <= 1'b0;
            end
        end
    end

endmodule

//--- header_latch.sv
/*
  Keeps the header bytes of the last download.
  Contents stay valid after the download ends and clear only on reset.
*/

`timescale 1ns/1ps

module header_latch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         header,
    input  logic                         ioctl_wr,
    input  romdl_bus_pkg::host_beat_t    beat,
    output romdl_bus_pkg::header_bytes_t hdr
);

    // slot index is taken from the low host address bits
    logic [$clog2(romdl_map_pkg::HEADER_LEN)-1:0] slot;

    assign slot = beat.addr[$clog2(romdl_map_pkg::HEADER_LEN)-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr <= '0;
        end else if (header && ioctl_wr) begin
            // header is only high while downloading, so stray strobes are ignored
            hdr[slot] <= beat.data;
        end
    end

endmodule

//--- sdram_prog_port.sv
/*
  Behavioural SDRAM programming port with four banks.
  A write is applied and acknowledged 2 cycles after prog_we is first seen.
  prog_we must drop before the next write is taken.
  No refresh, no timing model, read-back is for testing only.
*/

`timescale 1ns/1ps

module sdram_prog_port (
    input  logic                                clk,
    input  logic                                rst,
    input  romdl_bus_pkg::sdram_prog_t          prog,
    input  logic                                prog_we,
    input  logic [1:0]                          rd_ba,
    input  logic [romdl_map_pkg::BANK_AW-1:0]   rd_addr,
    output logic                                sdram_ack,
    output logic [15:0]                         rd_data
);

    // 0 idle, 1 request seen and written on the next edge
    logic        cnt;
    // set after an ack until the requester drops prog_we
    logic        hold;
    logic        do_wr;
    logic [1:0]  rd_ba_q;
    logic [15:0] bank_q [4];

    assign do_wr = cnt && prog_we;

    ////////////////////////////////////////////////////////////
    // handshake

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= 1'b0;
            hold      <= 1'b0;
            sdram_ack <= 1'b0;
        end else begin
            sdram_ack <= do_wr;
            if (!prog_we) begin
                // a request that drops early is abandoned without a write
                cnt  <= 1'b0;
                hold <= 1'b0;
            end else if (!cnt) begin
                // the same held request is never taken twice
                if (!hold) cnt <= 1'b1;
            end else begin
                cnt  <= 1'b0;
                hold <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // bank stores

    for (genvar i = 0; i < 4; i++) begin : g_bank
        mem_sync #(
            .word_t (logic [15:0]),
            .DEPTH  (romdl_map_pkg::BANK_WORDS),
            .AW     (romdl_map_pkg::BANK_AW)
        ) u_bank (
            .clk     (clk),
            .we      (do_wr && (prog.ba == 2'(i))),
            .waddr   (prog.addr[romdl_map_pkg::BANK_AW-1:0]),
            .wdata   (prog.data),
            .wmask_n (prog.mask),
            .raddr   (rd_addr),
            .rdata   (bank_q[i])
        );
    end

    // the bank select follows the registered read by one cycle
    always_ff @(posedge clk) begin
        rd_ba_q <= rd_ba;
    end

    assign rd_data = bank_q[rd_ba_q];

endmodule

//--- rom_load_top.sv
/*
  ROM download path: host byte stream to header, SDRAM banks and PROM.
  The host has no back-pressure, so strobes must be at least 4 cycles apart.
  SDRAM memory is updated 3 cycles after the strobe edge, the PROM 2 cycles after.
  Read-back ports have one cycle of latency and exist for testing.
*/

`timescale 1ns/1ps

module rom_load_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                downloading,
    input  romdl_bus_pkg::host_beat_t           beat,
    input  logic                                ioctl_wr,
    input  logic [1:0]                          rd_ba,
    input  logic [romdl_map_pkg::BANK_AW-1:0]   rd_addr,
    input  logic [romdl_map_pkg::PROM_AW-1:0]   prom_rd_addr,
    output logic [15:0]                         rd_data,
    output logic [7:0]                          prom_rd_data,
    output romdl_bus_pkg::header_bytes_t        hdr
);

    romdl_bus_pkg::sdram_prog_t prog;
    romdl_bus_pkg::prom_wr_t    prom;
    logic                       prog_we;
    logic                       prom_we;
    logic                       sdram_ack;
    logic                       header;

    rom_dwnld u_dwnld (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .beat        (beat),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog        (prog),
        .prog_we     (prog_we),
        .prom        (prom),
        .prom_we     (prom_we),
        .header      (header)
    );

    header_latch u_header (
        .clk      (clk),
        .rst      (rst),
        .header   (header),
        .ioctl_wr (ioctl_wr),
        .beat     (beat),
        .hdr      (hdr)
    );

    sdram_prog_port u_sdram (
        .clk       (clk),
        .rst       (rst),
        .prog      (prog),
        .prog_we   (prog_we),
        .rd_ba     (rd_ba),
        .rd_addr   (rd_addr),
        .sdram_ack (sdram_ack),
        .rd_data   (rd_data)
    );

    // PROM store holds bytes, so the lane mask is unused
    mem_sync #(
        .word_t (logic [7:0]),
        .DEPTH  (romdl_map_pkg::PROM_BYTES),
        .AW     (romdl_map_pkg::PROM_AW)
    ) u_prom (
        .clk     (clk),
        .we      (prom_we),
        .waddr   (prom.addr[romdl_map_pkg::PROM_AW-1:0]),
        .wdata   (prom.data),
        .wmask_n (2'b11),
        .raddr   (prom_rd_addr),
        .rdata   (prom_rd_data)
    );

endmodule

//--- tb_rom_load.sv
/*
  Directed testbench for the ROM download path.
  Strobes are sent 6 cycles apart, above the 4-cycle minimum of the host bus.
  Only SDRAM words with both lanes written are read back, since memories are not reset.
*/

`timescale 1ns/1ps

module tb_rom_load;

    // bytes sent by all tests together, used to size the watchdog
    localparam int TOTAL_BYTES     = 116;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 6 + 400;
    localparam logic [24:0] HDR    = 25'(romdl_map_pkg::HEADER_LEN);

    // even post-header offsets that straddle each bank start and bank end
    localparam logic [24:0] EDGE_OFFS [7] = '{25'h0fe, 25'h100, 25'h1fe, 25'h200,
                                              25'h2fe, 25'h300, 25'h37e};

    logic                               clk = 1'b0;
    logic                               rst;
    logic                               downloading;
    romdl_bus_pkg::host_beat_t          beat;
    logic                               ioctl_wr;
    logic [1:0]                         rd_ba;
    logic [romdl_map_pkg::BANK_AW-1:0]  rd_addr;
    logic [romdl_map_pkg::PROM_AW-1:0]  prom_rd_addr;
    logic [15:0]                        rd_data;
    logic [7:0]                         prom_rd_data;
    romdl_bus_pkg::header_bytes_t       hdr;

    // expected contents, built from the routing rules as bytes are sent
    logic [15:0]                  bank_exp [4][romdl_map_pkg::BANK_WORDS];
    logic [7:0]                   prom_exp [romdl_map_pkg::PROM_BYTES];
    romdl_bus_pkg::header_bytes_t hdr_exp;

    logic [31:0] rng        = 32'hc62;
    int          err_count  = 0;
    int          err_mark   = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    always #50 clk = ~clk;

    rom_load_top UUT (
        .clk          (clk),
        .rst          (rst),
        .downloading  (downloading),
        .beat         (beat),
        .ioctl_wr     (ioctl_wr),
        .rd_ba        (rd_ba),
        .rd_addr      (rd_addr),
        .prom_rd_addr (prom_rd_addr),
        .rd_data      (rd_data),
        .prom_rd_data (prom_rd_data),
        .hdr          (hdr)
    );

    ////////////////////////////////////////////////////////////
    // image data and reference model

    // xorshift32, the low byte of each new state is one image byte
    function automatic logic [7:0] rand_byte();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng[7:0];
    endfunction

    // bank, word and byte lane of a post-header byte address below the PROM
    task automatic locate(input logic [24:0] part, output logic [1:0] bank,
                          output logic [romdl_map_pkg::BANK_AW-1:0] word,
                          output logic upper);
        logic [24:0] off;
        if (part >= romdl_map_pkg::BA3_START) begin
            bank = 2'd3;
            off  = part - romdl_map_pkg::BA3_START;
        end else if (part >= romdl_map_pkg::BA2_START) begin
            bank = 2'd2;
            off  = part - romdl_map_pkg::BA2_START;
        end else if (part >= romdl_map_pkg::BA1_START) begin
            bank = 2'd1;
            off  = part - romdl_map_pkg::BA1_START;
        end else begin
            bank = 2'd0;
            off  = part;
        end
        word  = off[romdl_map_pkg::BANK_AW:1];
        // even offsets fill the upper byte, the swap flag turns this around
        upper = (off[0] == romdl_map_pkg::SWAB);
    endtask

    task automatic model_byte(input logic [24:0] addr, input logic [7:0] data);
        logic [24:0]                       part;
        logic [1:0]                        bank;
        logic [romdl_map_pkg::BANK_AW-1:0] word;
        logic                              upper;
        part = addr - HDR;
        if (addr < HDR) begin
            hdr_exp[addr[3:0]] = data;
        end else if (part >= romdl_map_pkg::PROM_START) begin
            prom_exp[part[romdl_map_pkg::PROM_AW-1:0]] = data;
        end else begin
            locate(part, bank, word, upper);
            if (upper) bank_exp[bank][word][15:8] = data;
            else bank_exp[bank][word][7:0] = data;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus tasks

    // one strobe, then 4 idle cycles so the SDRAM write and its ack complete
    task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        beat.addr = addr;
        beat.data = data;
        ioctl_wr  = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic load_byte(input logic [24:0] addr, input logic [7:0] data);
        send_byte(addr, data);
        model_byte(addr, data);
    endtask

    task automatic read_word(input logic [1:0] ba,
                             input logic [romdl_map_pkg::BANK_AW-1:0] addr,
                             output logic [15:0] data);
        @(posedge clk);
        #1;
        rd_ba   = ba;
        rd_addr = addr;
        @(posedge clk);
        #1;
        data = rd_data;
    endtask

    task automatic read_prom(input logic [romdl_map_pkg::PROM_AW-1:0] addr,
                             output logic [7:0] data);
        @(posedge clk);
        #1;
        prom_rd_addr = addr;
        @(posedge clk);
        #1;
        data = prom_rd_data;
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_word(input logic [15:0] got, input logic [15:0] exp,
                              input string what);
        if (got !== exp) begin
            err_count++;
            $display("ERROR at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp,
                              input string what);
        if (got !== exp) begin
            err_count++;
            $display("ERROR at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_header(input romdl_bus_pkg::header_bytes_t got,
                                input romdl_bus_pkg::header_bytes_t exp,
                                input string what);
        if (got !== exp) begin
            err_count++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic verify_word(input logic [1:0] ba,
                               input logic [romdl_map_pkg::BANK_AW-1:0] addr);
        logic [15:0] got;
        read_word(ba, addr, got);
        check_word(got, bank_exp[ba][addr], $sformatf("bank %0d word %0d", ba, addr));
    endtask

    task automatic verify_prom(input logic [romdl_map_pkg::PROM_AW-1:0] addr);
        logic [7:0] got;
        read_prom(addr, got);
        check_byte(got, prom_exp[addr], $sformatf("prom byte %0d", addr));
    endtask

    task automatic finish_test(input string name);
        if (err_count == err_mark) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d mismatches", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests

    // bank 0 word 0 is filled first, so a header byte leaking there would show
    task automatic test_header_capture();
        int i;
        check_header(hdr, '0, "header after reset");
        load_byte(HDR, rand_byte());
        load_byte(HDR + 25'd1, rand_byte());
        for (i = 0; i < romdl_map_pkg::HEADER_LEN; i++) begin
            load_byte(25'(i), rand_byte());
        end
        check_header(hdr, hdr_exp, "header bytes");
        verify_word(2'd0, '0);
        finish_test("header_capture");
    endtask

    task automatic test_bank0_packing();
        int i;
        for (i = 0; i < 64; i++) begin
            load_byte(HDR + 25'(i), rand_byte());
        end
        for (i = 0; i < 32; i++) begin
            verify_word(2'd0, 7'(i));
        end
        finish_test("bank0_packing");
    endtask

    task automatic test_bank_select();
        int                                i;
        logic [1:0]                        bank;
        logic [romdl_map_pkg::BANK_AW-1:0] word;
        logic                              upper;
        for (i = 0; i < 7; i++) begin
            load_byte(EDGE_OFFS[i] + HDR, rand_byte());
            load_byte(EDGE_OFFS[i] + HDR + 25'd1, rand_byte());
        end
        for (i = 0; i < 7; i++) begin
            locate(EDGE_OFFS[i], bank, word, upper);
            verify_word(bank, word);
        end
        finish_test("bank_select");
    endtask

    // PROM addresses wrap to the store depth, so 0x380 reads back at 0
    task automatic test_prom_routing();
        int i;
        for (i = 0; i < 16; i++) begin
            load_byte(romdl_map_pkg::PROM_START + HDR + 25'(i), rand_byte());
        end
        for (i = 0; i < 16; i++) begin
            verify_prom(7'(i));
        end
        verify_word(2'd3, 7'd0);
        verify_word(2'd3, 7'd63);
        finish_test("prom_routing");
    endtask

    task automatic test_download_abort();
        // this SDRAM write is still waiting for ack when downloading drops
        @(posedge clk);
        #1;
        beat.addr = HDR;
        beat.data = ~bank_exp[0][0][15:8];
        ioctl_wr  = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr    = 1'b0;
        downloading = 1'b0;
        repeat (4) @(posedge clk);
        // with downloading low every strobe is ignored, the model stays as it is
        send_byte(25'd3, ~hdr_exp[3]);
        send_byte(romdl_map_pkg::BA1_START + HDR, ~bank_exp[1][0][15:8]);
        send_byte(romdl_map_pkg::PROM_START + HDR + 25'd5, ~prom_exp[5]);
        check_header(hdr, hdr_exp, "header after abort");
        verify_word(2'd0, 7'd0);
        verify_word(2'd1, 7'd0);
        verify_prom(7'd5);
        finish_test("download_abort");
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        rst          = 1'b1;
        downloading  = 1'b0;
        beat         = '0;
        ioctl_wr     = 1'b0;
        rd_ba        = 2'd0;
        rd_addr      = '0;
        prom_rd_addr = '0;
        hdr_exp      = '0;
        repeat (3) @(posedge clk);
        #1;
        rst         = 1'b0;
        downloading = 1'b1;
        test_header_capture();
        test_bank0_packing();
        test_bank_select();
        test_prom_routing();
        test_download_abort();
        $display("summary: %0d ok, %0d failing, %0d mismatches",
                 pass_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- sim.f
romdl_map_pkg.sv
romdl_bus_pkg.sv
mem_sync.sv
rom_dwnld.sv
header_latch.sv
sdram_prog_port.sv
rom_load_top.sv
tb_rom_load.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log
verilator --binary --timing --top-module tb_rom_load -f sim.f -o tb_rom_load \
    && ./obj_dir/tb_rom_load > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -qx "TESTS PASSED" sim.log \
    && echo "result: pass" \
    || { echo "result: fail, see sim.log"; exit 1; }
